/* rtl/mmu_defines.svh */
`ifndef MMU_DEFINES_SVH
`define MMU_DEFINES_SVH

// processor word address, A23..A1
`define MMU_ADDR_W 23

// context register
`define MMU_CTX_W 3

// virtual address fields
`define MMU_SEG_W 9
`define MMU_PAGE_IDX_W 4
`define MMU_OFFSET_W 10

// map entry contents
`define MMU_PMEG_W 8
`define MMU_PPN_W 12

// map depths, indexed by ctx+segment and pmeg+page
`define MMU_SMAP_DEPTH (1 << (`MMU_CTX_W + `MMU_SEG_W))
`define MMU_PMAP_DEPTH (1 << (`MMU_PMEG_W + `MMU_PAGE_IDX_W))

// data bus
`define MMU_DATA_W 16

// function code of control space
`define MMU_FC_CTL 3

`endif

/* rtl/mmu_pkg.sv */
`default_nettype none

`include "mmu_defines.svh"

package mmu_pkg;

   typedef logic [`MMU_ADDR_W-1:0] vaddr_t;
   typedef logic [`MMU_CTX_W-1:0]  ctx_t;
   typedef logic [`MMU_PMEG_W-1:0] pmeg_t;
   typedef logic [`MMU_PPN_W-1:0]  ppn_t;
   typedef logic [2:0]             fc_t;
   typedef logic [`MMU_DATA_W-1:0] data_t;

   // control space target, from A3..A1
   typedef enum logic [2:0] {
      SEL_PMAP_LO,
      SEL_PMAP_HI,
      SEL_SMAP,
      SEL_CTX,
      SEL_BERR,
      SEL_DIAG,
      SEL_NONE
   } ctl_sel_e;

   // page table entry, flags above ppn
   typedef struct packed {
      logic       valid;
      logic [5:0] prot;
      logic [1:0] mem_type;
      logic       acc;
      logic       mod;
      ppn_t       ppn;
   } pte_t;

   typedef struct packed {
      fc_t    fc;
      logic   rw;
      vaddr_t vaddr;
      data_t  wdata;
   } req_t;

   typedef struct packed {
      req_t     req;
      ctx_t     ctx;
      ctl_sel_e sel;
      logic     is_ctl;
      pmeg_t    pmeg;
      pte_t     pte;
      data_t    rdata;
   } stage_t;

   typedef struct packed {
      logic [`MMU_PPN_W+`MMU_OFFSET_W-1:0] paddr;
      logic [1:0]                         mem_type;
      logic                               berr;
      data_t                              rdata;
   } rsp_t;

endpackage

`default_nettype wire

/* rtl/mmu_cycle_capture.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_defines.svh"

module mmu_cycle_capture (
   input  wire              AS,
   input  wire              P_RESET_n,
   input  logic             req_valid,
   input  mmu_pkg::req_t    req,
   output logic             s1_valid,
   output mmu_pkg::stage_t  s1
);

   logic              cap_valid;
   mmu_pkg::req_t     cap_req;
   mmu_pkg::ctx_t     ctx_q;
   mmu_pkg::stage_t   s1_nxt;
   logic              ctx_wr;

   // ------------------------------------------------------------------
   // request capture
   // ------------------------------------------------------------------
   always_ff @(posedge AS or negedge P_RESET_n)
   begin
      if (!P_RESET_n)
         cap_valid <= 1'b0;
      else
         cap_valid <= req_valid;
   end

   always_ff @(posedge AS)
   begin
      cap_req <= req;
   end

   // ------------------------------------------------------------------
   // control space decode
   // ------------------------------------------------------------------
   always_comb
   begin
      s1_nxt        = '0;
      s1_nxt.req    = cap_req;
      s1_nxt.ctx    = ctx_q;
      s1_nxt.is_ctl = (cap_req.fc == mmu_pkg::fc_t'(`MMU_FC_CTL));
      s1_nxt.sel    = mmu_pkg::SEL_NONE;
      if (s1_nxt.is_ctl)
      begin
         // A3..A1
         case (cap_req.vaddr[2:0])
            3'b100:  s1_nxt.sel = mmu_pkg::SEL_PMAP_HI;
            3'b101:  s1_nxt.sel = mmu_pkg::SEL_PMAP_LO;
            3'b110:  s1_nxt.sel = mmu_pkg::SEL_SMAP;
            3'b111:  s1_nxt.sel = mmu_pkg::SEL_CTX;
            3'b010:  s1_nxt.sel = mmu_pkg::SEL_BERR;
            3'b001:  s1_nxt.sel = mmu_pkg::SEL_DIAG;
            default: s1_nxt.sel = mmu_pkg::SEL_NONE;
         endcase
      end
      if (s1_nxt.sel == mmu_pkg::SEL_CTX && cap_req.rw)
         s1_nxt.rdata = mmu_pkg::data_t'(ctx_q);
   end

   assign ctx_wr = cap_valid && (s1_nxt.sel == mmu_pkg::SEL_CTX) && !cap_req.rw;

   // context register, new value seen by the next item
   always_ff @(posedge AS or negedge P_RESET_n)
   begin
      if (!P_RESET_n)
      begin
         s1_valid <= 1'b0;
         ctx_q    <= '0;
      end
      else
      begin
         s1_valid <= cap_valid;
         if (ctx_wr)
            ctx_q <= cap_req.wdata[`MMU_CTX_W-1:0];
      end
   end

   always_ff @(posedge AS)
   begin
      s1 <= s1_nxt;
   end

   a_fc_known : assert property (@(posedge AS) disable iff (!P_RESET_n)
      req_valid |-> !$isunknown(req.fc));

endmodule

`default_nettype wire

/* rtl/mmu_segment_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_defines.svh"

module mmu_segment_stage (
   input  wire              AS,
   input  wire              P_RESET_n,
   input  logic             s1_valid,
   input  mmu_pkg::stage_t  s1,
   output logic             s2_valid,
   output mmu_pkg::stage_t  s2
);

   mmu_pkg::pmeg_t   smap [`MMU_SMAP_DEPTH];
   logic [`MMU_CTX_W+`MMU_SEG_W-1:0] smap_idx;
   mmu_pkg::pmeg_t   smap_rd;
   mmu_pkg::stage_t  s2_nxt;
   logic             smap_wr;

   // context and A23..A15
   assign smap_idx = {s1.ctx, s1.req.vaddr[`MMU_ADDR_W-1 -: `MMU_SEG_W]};
   assign smap_rd  = smap[smap_idx];

   assign smap_wr = s1_valid && (s1.sel == mmu_pkg::SEL_SMAP) && !s1.req.rw;

   always_comb
   begin
      s2_nxt      = s1;
      s2_nxt.pmeg = smap_rd;
      if (s1.sel == mmu_pkg::SEL_SMAP && s1.req.rw)
         s2_nxt.rdata = mmu_pkg::data_t'(smap_rd);
   end

   always_ff @(posedge AS or negedge P_RESET_n)
   begin
      if (!P_RESET_n)
         s2_valid <= 1'b0;
      else
         s2_valid <= s1_valid;
   end

   always_ff @(posedge AS)
   begin
      s2 <= s2_nxt;
      if (smap_wr)
         smap[smap_idx] <= s1.req.wdata[`MMU_PMEG_W-1:0];
   end

endmodule

`default_nettype wire

/* rtl/mmu_page_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_defines.svh"

module mmu_page_stage (
   input  wire              AS,
   input  wire              P_RESET_n,
   input  logic             s2_valid,
   input  mmu_pkg::stage_t  s2,
   output logic             s3_valid,
   output mmu_pkg::stage_t  s3
);

   // valid, prot, type, acc, mod
   localparam int FLAG_W = $bits(mmu_pkg::pte_t) - `MMU_PPN_W;

   mmu_pkg::pte_t    pmap [`MMU_PMAP_DEPTH];
   logic [`MMU_PMEG_W+`MMU_PAGE_IDX_W-1:0] pmap_idx;
   mmu_pkg::pte_t    pmap_rd;
   mmu_pkg::pte_t    pmap_wd;
   mmu_pkg::stage_t  s3_nxt;
   logic             pmap_sel;
   logic             pmap_wr;

   // pmeg and A14..A11
   assign pmap_idx = {s2.pmeg, s2.req.vaddr[`MMU_OFFSET_W +: `MMU_PAGE_IDX_W]};
   assign pmap_rd  = pmap[pmap_idx];

   assign pmap_sel = (s2.sel == mmu_pkg::SEL_PMAP_LO) || (s2.sel == mmu_pkg::SEL_PMAP_HI);
   assign pmap_wr  = s2_valid && pmap_sel && !s2.req.rw;

   // only one half of the entry changes per write
   always_comb
   begin
      pmap_wd = pmap_rd;
      if (s2.sel == mmu_pkg::SEL_PMAP_LO)
         pmap_wd.ppn = s2.req.wdata[`MMU_PPN_W-1:0];
      else
         {pmap_wd.valid, pmap_wd.prot, pmap_wd.mem_type, pmap_wd.acc, pmap_wd.mod} =
            s2.req.wdata[FLAG_W-1:0];
   end

   always_comb
   begin
      s3_nxt     = s2;
      s3_nxt.pte = pmap_rd;
      if (s2.req.rw && s2.sel == mmu_pkg::SEL_PMAP_LO)
         s3_nxt.rdata = mmu_pkg::data_t'(pmap_rd.ppn);
      else if (s2.req.rw && s2.sel == mmu_pkg::SEL_PMAP_HI)
         s3_nxt.rdata = mmu_pkg::data_t'({pmap_rd.valid, pmap_rd.prot, pmap_rd.mem_type,
                                          pmap_rd.acc, pmap_rd.mod});
   end

   always_ff @(posedge AS or negedge P_RESET_n)
   begin
      if (!P_RESET_n)
         s3_valid <= 1'b0;
      else
         s3_valid <= s2_valid;
   end

   always_ff @(posedge AS)
   begin
      s3 <= s3_nxt;
      if (pmap_wr)
         pmap[pmap_idx] <= pmap_wd;
   end

endmodule

`default_nettype wire

/* rtl/mmu_access_check.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_defines.svh"

module mmu_access_check (
   input  wire              AS,
   input  wire              P_RESET_n,
   input  logic             s3_valid,
   input  mmu_pkg::stage_t  s3,
   output logic             rsp_valid,
   output mmu_pkg::rsp_t    rsp,
   output logic [7:0]       leds
);

   mmu_pkg::data_t  cause_q;
   mmu_pkg::rsp_t   rsp_nxt;
   logic            sup;
   logic            prog;
   logic            prot_ok;
   logic            invalid;
   logic            prot_err;
   logic            fault;
   logic            diag_wr;

   // ------------------------------------------------------------------
   // protection check
   // ------------------------------------------------------------------
   always_comb
   begin
      sup  = s3.req.fc[2];
      // program space is fc 2 or 6
      prog = (s3.req.fc[1:0] == 2'b10);
      if (!s3.req.rw)
         prot_ok = sup ? s3.pte.prot[5] : s3.pte.prot[2];
      else if (prog)
         prot_ok = sup ? s3.pte.prot[3] : s3.pte.prot[0];
      else
         prot_ok = sup ? s3.pte.prot[4] : s3.pte.prot[1];
   end

   assign invalid  = !s3.is_ctl && !s3.pte.valid;
   assign prot_err = !s3.is_ctl && s3.pte.valid && !prot_ok;
   assign fault    = invalid || prot_err;

   assign diag_wr = s3_valid && (s3.sel == mmu_pkg::SEL_DIAG) && !s3.req.rw;

   // ------------------------------------------------------------------
   // response
   // ------------------------------------------------------------------
   always_comb
   begin
      rsp_nxt       = '0;
      rsp_nxt.berr  = fault;
      rsp_nxt.rdata = s3.rdata;
      if (!s3.is_ctl)
      begin
         rsp_nxt.paddr    = {s3.pte.ppn, s3.req.vaddr[`MMU_OFFSET_W-1:0]};
         rsp_nxt.mem_type = s3.pte.mem_type;
      end
      else if (s3.req.rw)
      begin
         case (s3.sel)
            mmu_pkg::SEL_BERR: rsp_nxt.rdata = cause_q;
            mmu_pkg::SEL_DIAG: rsp_nxt.rdata = mmu_pkg::data_t'(leds);
            default:           rsp_nxt.rdata = s3.rdata;
         endcase
      end
   end

   // cause is held until the next fault
   always_ff @(posedge AS or negedge P_RESET_n)
   begin
      if (!P_RESET_n)
      begin
         rsp_valid <= 1'b0;
         cause_q   <= '0;
         leds      <= '0;
      end
      else
      begin
         rsp_valid <= s3_valid;
         if (s3_valid && fault)
            cause_q <= mmu_pkg::data_t'({prot_err, invalid});
         if (diag_wr)
            leds <= s3.req.wdata[7:0];
      end
   end

   always_ff @(posedge AS)
   begin
      rsp <= rsp_nxt;
   end

   a_no_ctl_berr : assert property (@(posedge AS) disable iff (!P_RESET_n)
      (s3_valid && s3.req.fc == mmu_pkg::fc_t'(`MMU_FC_CTL)) |=> !rsp.berr);

endmodule

`default_nettype wire

/* rtl/sun2_mmu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sun2_mmu_top (
   input  wire             AS,
   input  wire             P_RESET_n,
   input  logic            req_valid,
   input  mmu_pkg::req_t   req,
   output logic            rsp_valid,
   output mmu_pkg::rsp_t   rsp,
   output logic [7:0]      leds
);

   logic             s1_valid;
   logic             s2_valid;
   logic             s3_valid;
   mmu_pkg::stage_t  s1;
   mmu_pkg::stage_t  s2;
   mmu_pkg::stage_t  s3;

   // context, then segment map, page map and check
   mmu_cycle_capture u_capture (
      .AS        (AS),
      .P_RESET_n (P_RESET_n),
      .req_valid (req_valid),
      .req       (req),
      .s1_valid  (s1_valid),
      .s1        (s1)
   );

   mmu_segment_stage u_segment (
      .AS        (AS),
      .P_RESET_n (P_RESET_n),
      .s1_valid  (s1_valid),
      .s1        (s1),
      .s2_valid  (s2_valid),
      .s2        (s2)
   );

   mmu_page_stage u_page (
      .AS        (AS),
      .P_RESET_n (P_RESET_n),
      .s2_valid  (s2_valid),
      .s2        (s2),
      .s3_valid  (s3_valid),
      .s3        (s3)
   );

   mmu_access_check u_check (
      .AS        (AS),
      .P_RESET_n (P_RESET_n),
      .s3_valid  (s3_valid),
      .s3        (s3),
      .rsp_valid (rsp_valid),
      .rsp       (rsp),
      .leds      (leds)
   );

endmodule

`default_nettype wire

/* tb/mmu_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module mmu_checker (
   input  wire            AS,
   input  logic           rsp_valid,
   input  mmu_pkg::rsp_t  rsp,
   input  logic [7:0]     leds,
   input  logic           exp_valid,
   input  mmu_pkg::rsp_t  exp_rsp,
   input  logic [7:0]     exp_leds,
   input  int             exp_row,
   input  logic           report,
   output int             done_count,
   output int             fail_count
);

   localparam int LATENCY = 4;

   mmu_pkg::rsp_t  exp_q [$];
   logic [7:0]     leds_q [$];
   int             row_q [$];
   int             cyc_q [$];
   int             cycle;
   int             pass_count;

   initial
   begin
      done_count = 0;
      fail_count = 0;
      pass_count = 0;
      cycle      = 0;
   end

   task automatic show_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] want);
      $display("CHECK FAILED at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
   endtask

   // requests enter on the same edge the DUT samples them
   always @(posedge AS)
   begin
      if (exp_valid)
      begin
         exp_q.push_back(exp_rsp);
         leds_q.push_back(exp_leds);
         row_q.push_back(exp_row);
         cyc_q.push_back(cycle);
      end
      cycle++;
   end

   // ---------------------------------------------------------------------
   // compare mid cycle
   // ---------------------------------------------------------------------
   always @(negedge AS)
   begin : compare
      mmu_pkg::rsp_t want;
      logic [7:0]    want_leds;
      int            row;
      int            issued;
      int            lat;
      int            errs;
      if (rsp_valid === 1'b1)
      begin
         if (exp_q.size() == 0)
         begin
            $display("ERROR at %0t ns: response seen with no request outstanding", $time);
            fail_count++;
         end
         else
         begin
            want      = exp_q.pop_front();
            want_leds = leds_q.pop_front();
            row       = row_q.pop_front();
            issued    = cyc_q.pop_front();
            lat       = cycle - issued - 1;
            errs      = 0;
            if (lat != LATENCY)
            begin
               $display("ERROR at %0t ns: row %0d answered %0d cycles after issue, expected %0d",
                        $time, row, lat, LATENCY);
               errs++;
            end
            if (rsp.paddr !== want.paddr)
            begin
               show_mismatch("rsp.paddr", rsp.paddr, want.paddr);
               errs++;
            end
            if (rsp.mem_type !== want.mem_type)
            begin
               show_mismatch("rsp.mem_type", rsp.mem_type, want.mem_type);
               errs++;
            end
            if (rsp.berr !== want.berr)
            begin
               show_mismatch("rsp.berr", rsp.berr, want.berr);
               errs++;
            end
            if (rsp.rdata !== want.rdata)
            begin
               show_mismatch("rsp.rdata", rsp.rdata, want.rdata);
               errs++;
            end
            if (leds !== want_leds)
            begin
               show_mismatch("leds", leds, want_leds);
               errs++;
            end
            $display("row %0d %s at %0t ns", row, (errs == 0) ? "passed" : "FAILED", $time);
            done_count++;
            if (errs == 0)
               pass_count++;
            else
               fail_count++;
         end
      end
   end

   always @(posedge report)
   begin
      $display("%0d rows checked, %0d passed, %0d failures", done_count, pass_count,
               fail_count);
   end

endmodule

`default_nettype wire

/* tb/tb_sun2_mmu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_defines.svh"

module tb_sun2_mmu;

   localparam int HALF_PERIOD    = 50;
   localparam int DRIVE_DELAY    = 5;
   localparam int TIMEOUT_CYCLES = 50;

   // A3..A1 in control space
   localparam logic [2:0] A_DIAG    = 3'b001;
   localparam logic [2:0] A_BERR    = 3'b010;
   localparam logic [2:0] A_PMAP_HI = 3'b100;
   localparam logic [2:0] A_PMAP_LO = 3'b101;
   localparam logic [2:0] A_SMAP    = 3'b110;
   localparam logic [2:0] A_CTX     = 3'b111;

   localparam mmu_pkg::fc_t FC_USER_DATA = 3'd1;
   localparam mmu_pkg::fc_t FC_USER_PROG = 3'd2;
   localparam mmu_pkg::fc_t FC_CTL       = mmu_pkg::fc_t'(`MMU_FC_CTL);
   localparam mmu_pkg::fc_t FC_SUP_DATA  = 3'd5;
   localparam mmu_pkg::fc_t FC_SUP_PROG  = 3'd6;

   localparam logic [`MMU_SEG_W-1:0] SEG = 9'h012;

   logic            AS;
   logic            P_RESET_n;
   logic            req_valid;
   mmu_pkg::req_t   req;
   logic            rsp_valid;
   mmu_pkg::rsp_t   rsp;
   logic [7:0]      leds;

   logic            exp_valid;
   mmu_pkg::rsp_t   exp_rsp;
   logic [7:0]      exp_leds;
   int              exp_row;
   logic            report;
   int              done_count;
   int              fail_count;

   // stimulus table
   mmu_pkg::req_t   row_req [$];
   mmu_pkg::rsp_t   row_rsp [$];
   logic [7:0]      row_leds [$];
   int              row_gap [$];
   int              gap;
   logic [7:0]      cur_leds;

   mmu_pkg::pte_t   pte_a;
   mmu_pkg::pte_t   pte_b;
   mmu_pkg::pte_t   pte_inv;
   mmu_pkg::pte_t   pte_prot;

   always #HALF_PERIOD AS = ~AS;

   sun2_mmu_top u_dut (
      .AS        (AS),
      .P_RESET_n (P_RESET_n),
      .req_valid (req_valid),
      .req       (req),
      .rsp_valid (rsp_valid),
      .rsp       (rsp),
      .leds      (leds)
   );

   mmu_checker u_checker (
      .AS         (AS),
      .rsp_valid  (rsp_valid),
      .rsp        (rsp),
      .leds       (leds),
      .exp_valid  (exp_valid),
      .exp_rsp    (exp_rsp),
      .exp_leds   (exp_leds),
      .exp_row    (exp_row),
      .report     (report),
      .done_count (done_count),
      .fail_count (fail_count)
   );

   // ---------------------------------------------------------------------
   // expected value rules
   // ---------------------------------------------------------------------
   function automatic mmu_pkg::vaddr_t ctl_addr(input logic [8:0] seg, input logic [3:0] pg,
                                                input logic [2:0] sel);
      return {seg, pg, 7'b0, sel};
   endfunction

   function automatic mmu_pkg::vaddr_t page_addr(input logic [3:0] pg, input logic [9:0] off);
      return {SEG, pg, off};
   endfunction

   function automatic mmu_pkg::pte_t make_pte(input logic valid, input logic [5:0] prot,
                                              input logic [1:0] mt, input mmu_pkg::ppn_t ppn);
      mmu_pkg::pte_t p;
      p          = '0;
      p.valid    = valid;
      p.prot     = prot;
      p.mem_type = mt;
      p.ppn      = ppn;
      return p;
   endfunction

   // pmap high half holds valid, prot, type, acc and mod
   function automatic mmu_pkg::data_t flag_bits(input mmu_pkg::pte_t p);
      return mmu_pkg::data_t'({p.valid, p.prot, p.mem_type, p.acc, p.mod});
   endfunction

   // supervisor group is prot 5..3, user group 2..0; W, R, X from the top
   function automatic logic access_allowed(input logic [5:0] prot, input mmu_pkg::fc_t fc,
                                           input logic rw);
      int base;
      int bit_no;
      base = fc[2] ? 3 : 0;
      if (!rw)
         bit_no = base + 2;
      else if (fc == 3'd2 || fc == 3'd6)
         bit_no = base;
      else
         bit_no = base + 1;
      return prot[bit_no];
   endfunction

   // ---------------------------------------------------------------------
   // table building
   // ---------------------------------------------------------------------
   task automatic add_row(input mmu_pkg::fc_t fc, input logic rw, input mmu_pkg::vaddr_t va,
                          input mmu_pkg::data_t wdata, input mmu_pkg::rsp_t want);
      mmu_pkg::req_t r;
      r       = '0;
      r.fc    = fc;
      r.rw    = rw;
      r.vaddr = va;
      r.wdata = wdata;
      row_req.push_back(r);
      row_rsp.push_back(want);
      row_leds.push_back(cur_leds);
      row_gap.push_back(gap);
   endtask

   task automatic write_ctl(input mmu_pkg::vaddr_t va, input mmu_pkg::data_t d);
      if (va[2:0] == A_DIAG)
         cur_leds = d[7:0];
      add_row(FC_CTL, 1'b0, va, d, '0);
   endtask

   task automatic read_ctl(input mmu_pkg::vaddr_t va, input mmu_pkg::data_t want_data);
      mmu_pkg::rsp_t want;
      want       = '0;
      want.rdata = want_data;
      add_row(FC_CTL, 1'b1, va, '0, want);
   endtask

   task automatic access_page(input mmu_pkg::fc_t fc, input logic rw, input logic [3:0] pg,
                              input logic [9:0] off, input mmu_pkg::pte_t p);
      mmu_pkg::rsp_t want;
      want          = '0;
      want.paddr    = {p.ppn, off};
      want.mem_type = p.mem_type;
      want.berr     = !p.valid || !access_allowed(p.prot, fc, rw);
      add_row(fc, rw, page_addr(pg, off), 16'h0, want);
   endtask

   task automatic write_pte(input logic [3:0] pg, input mmu_pkg::pte_t p);
      write_ctl(ctl_addr(SEG, pg, A_PMAP_LO), mmu_pkg::data_t'(p.ppn));
      write_ctl(ctl_addr(SEG, pg, A_PMAP_HI), flag_bits(p));
   endtask

   task automatic check_pte(input logic [3:0] pg, input mmu_pkg::pte_t p);
      read_ctl(ctl_addr(SEG, pg, A_PMAP_LO), mmu_pkg::data_t'(p.ppn));
      read_ctl(ctl_addr(SEG, pg, A_PMAP_HI), flag_bits(p));
   endtask

   task automatic build_table();
      gap      = 1;
      cur_leds = '0;
      // reset values
      read_ctl(ctl_addr(0, 0, A_CTX), 16'h0000);
      read_ctl(ctl_addr(0, 0, A_BERR), 16'h0000);
      write_ctl(ctl_addr(0, 0, A_CTX), 16'h0002);
      read_ctl(ctl_addr(0, 0, A_CTX), 16'h0002);
      write_ctl(ctl_addr(0, 0, A_DIAG), 16'h5aa5);
      read_ctl(ctl_addr(0, 0, A_DIAG), 16'h00a5);
      write_ctl(ctl_addr(0, 0, A_DIAG), 16'h003c);
      read_ctl(ctl_addr(0, 0, A_DIAG), 16'h003c);
      // maps of context 2
      write_ctl(ctl_addr(SEG, 0, A_SMAP), 16'h0021);
      read_ctl(ctl_addr(SEG, 0, A_SMAP), 16'h0021);
      write_pte(3, pte_a);
      write_pte(4, pte_inv);
      write_pte(5, pte_prot);
      check_pte(3, pte_a);
      check_pte(4, pte_inv);
      check_pte(5, pte_prot);
      // same segment in context 5
      write_ctl(ctl_addr(0, 0, A_CTX), 16'h0005);
      write_ctl(ctl_addr(SEG, 0, A_SMAP), 16'h0052);
      read_ctl(ctl_addr(SEG, 0, A_SMAP), 16'h0052);
      write_pte(3, pte_b);
      check_pte(3, pte_b);
      write_ctl(ctl_addr(0, 0, A_CTX), 16'h0002);
      read_ctl(ctl_addr(SEG, 0, A_SMAP), 16'h0021);
      check_pte(3, pte_a);
      // translation, then invalid page and protection
      access_page(FC_USER_DATA, 1'b1, 3, 10'h155, pte_a);
      access_page(FC_SUP_DATA, 1'b0, 3, 10'h3ff, pte_a);
      access_page(FC_SUP_PROG, 1'b1, 3, 10'h000, pte_a);
      access_page(FC_SUP_DATA, 1'b1, 4, 10'h020, pte_inv);
      read_ctl(ctl_addr(0, 0, A_BERR), 16'h0001);
      access_page(FC_USER_DATA, 1'b1, 5, 10'h001, pte_prot);
      access_page(FC_USER_DATA, 1'b0, 5, 10'h002, pte_prot);
      read_ctl(ctl_addr(0, 0, A_BERR), 16'h0002);
      access_page(FC_USER_PROG, 1'b1, 5, 10'h003, pte_prot);
      access_page(FC_SUP_DATA, 1'b1, 5, 10'h004, pte_prot);
      access_page(FC_SUP_DATA, 1'b0, 5, 10'h005, pte_prot);
      access_page(FC_SUP_PROG, 1'b1, 5, 10'h006, pte_prot);
      read_ctl(ctl_addr(0, 0, A_BERR), 16'h0002);
      // back to back from here
      gap = 0;
      access_page(FC_USER_PROG, 1'b1, 5, 10'h0f0, pte_prot);
      access_page(FC_USER_DATA, 1'b1, 4, 10'h0f1, pte_inv);
      read_ctl(ctl_addr(0, 0, A_BERR), 16'h0001);
      write_ctl(ctl_addr(0, 0, A_CTX), 16'h0005);
      access_page(FC_USER_DATA, 1'b1, 3, 10'h0aa, pte_b);
      write_ctl(ctl_addr(0, 0, A_CTX), 16'h0002);
      access_page(FC_USER_DATA, 1'b1, 3, 10'h0bb, pte_a);
      write_ctl(ctl_addr(0, 0, A_CTX), 16'h0005);
      access_page(FC_USER_DATA, 1'b1, 3, 10'h0cc, pte_b);
      write_ctl(ctl_addr(0, 0, A_CTX), 16'h0002);
      read_ctl(ctl_addr(0, 0, A_CTX), 16'h0002);
      // context 2 segment now points at pmeg 52
      write_ctl(ctl_addr(SEG, 0, A_SMAP), 16'h0052);
      access_page(FC_SUP_DATA, 1'b1, 3, 10'h011, pte_b);
      read_ctl(ctl_addr(SEG, 0, A_SMAP), 16'h0052);
      pte_b.ppn = 12'h777;
      write_ctl(ctl_addr(SEG, 3, A_PMAP_LO), 16'h0777);
      access_page(FC_USER_DATA, 1'b0, 3, 10'h022, pte_b);
      check_pte(3, pte_b);
      write_ctl(ctl_addr(0, 0, A_DIAG), 16'hf0c3);
      read_ctl(ctl_addr(0, 0, A_DIAG), 16'h00c3);
   endtask

   // ---------------------------------------------------------------------
   // reset, driving loop, final verdict
   // ---------------------------------------------------------------------
   initial
   begin : main
      int   cycles;
      logic timed_out;
      AS        = 1'b0;
      P_RESET_n = 1'b0;
      req_valid = 1'b0;
      req       = '0;
      exp_valid = 1'b0;
      exp_rsp   = '0;
      exp_leds  = '0;
      exp_row   = 0;
      report    = 1'b0;
      timed_out = 1'b0;
      pte_a     = make_pte(1'b1, 6'b111111, 2'b01, 12'habc);
      pte_inv   = make_pte(1'b0, 6'b111111, 2'b00, 12'h123);
      pte_prot  = make_pte(1'b1, 6'b011010, 2'b10, 12'h456);
      pte_b     = make_pte(1'b1, 6'b111111, 2'b11, 12'hdef);
      pte_b.acc = 1'b1;
      pte_b.mod = 1'b1;
      build_table();
      repeat (10) @(posedge AS);
      #DRIVE_DELAY;
      P_RESET_n = 1'b1;
      for (int i = 0; i < row_req.size(); i++)
      begin
         for (int g = 0; g < row_gap[i]; g++)
         begin
            @(posedge AS);
            #DRIVE_DELAY;
            req_valid = 1'b0;
            exp_valid = 1'b0;
         end
         @(posedge AS);
         #DRIVE_DELAY;
         req_valid = 1'b1;
         req       = row_req[i];
         exp_valid = 1'b1;
         exp_rsp   = row_rsp[i];
         exp_leds  = row_leds[i];
         exp_row   = i;
      end
      @(posedge AS);
      #DRIVE_DELAY;
      req_valid = 1'b0;
      exp_valid = 1'b0;
      cycles = 0;
      while (done_count < row_req.size() && cycles < TIMEOUT_CYCLES)
      begin
         @(posedge AS);
         cycles++;
      end
      if (done_count < row_req.size())
      begin
         $display("timeout: only %0d of %0d responses arrived", done_count, row_req.size());
         timed_out = 1'b1;
      end
      report = 1'b1;
      #1;
      if (timed_out || fail_count != 0)
         $display("Simulation failed");
      else
         $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

/* tb.f */
+incdir+rtl
rtl/mmu_pkg.sv
rtl/mmu_cycle_capture.sv
rtl/mmu_segment_stage.sv
rtl/mmu_page_stage.sv
rtl/mmu_access_check.sv
rtl/sun2_mmu_top.sv
tb/mmu_checker.sv
tb/tb_sun2_mmu.sv

/* Bender.yml */
package:
  name: sun2_mmu

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mmu_pkg.sv
      - rtl/mmu_cycle_capture.sv
      - rtl/mmu_segment_stage.sv
      - rtl/mmu_page_stage.sv
      - rtl/mmu_access_check.sv
      - rtl/sun2_mmu_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/mmu_checker.sv
      - tb/tb_sun2_mmu.sv
